// ==== flist.f ====
hdl/histPkg.sv
hdl/acqSequencer.sv
hdl/binAddressMapper.sv
hdl/histogramRam.sv
hdl/peakTracker.sv
hdl/windowCalculator.sv
hdl/histogramTop.sv
verification/tbClockGen.sv
verification/histogramTb_assert.sv
verification/histogramTb.sv

// ==== hdl/acqSequencer.sv ====
`timescale 1ns/1ps

module acqSequencer import histPkg::*; #(
    parameter int PIXEL_NUM  = PIXEL_NUM_DEF,
    parameter int SAMPLE_NUM = SAMPLE_NUM_DEF,
    parameter int ACQ_NUM    = ACQ_NUM_DEF,
    localparam int PIX_W     = idxWidth(PIXEL_NUM),
    localparam int SMP_W     = idxWidth(SAMPLE_NUM),
    localparam int ACQ_W     = idxWidth(ACQ_NUM)
) (
    input  logic             clk,
    input  logic             combin_res,
    input  logic             wrEn,
    output logic             accept,
    output logic             reportEn,
    output logic             clearHist,
    output logic             busy,
    output logic [PIX_W-1:0] pixel,
    output logic [PIX_W-1:0] reportPixel,
    output histPhase_e       phase
);

    seqState_e        state;
    logic [SMP_W-1:0] sampleCnt;
    logic [ACQ_W-1:0] acqCnt;
    // shared step counter for drain and report
    logic [PIX_W-1:0] stepCnt;
    logic             lastSample;
    logic             lastPixel;
    logic             lastAcq;

    // samples only taken while accumulating
    assign accept      = wrEn && (state == SEQ_ACCUM);
    assign busy        = (state != SEQ_ACCUM);
    assign reportEn    = (state == SEQ_REPORT);
    assign clearHist   = (state == SEQ_CLEAR);
    assign reportPixel = stepCnt;

    assign lastSample = (sampleCnt == SMP_W'(SAMPLE_NUM - 1));
    assign lastPixel  = (pixel == PIX_W'(PIXEL_NUM - 1));
    assign lastAcq    = (acqCnt == ACQ_W'(ACQ_NUM - 1));

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state     <= SEQ_ACCUM;
            sampleCnt <= '0;
            pixel     <= '0;
            acqCnt    <= '0;
            stepCnt   <= '0;
            phase     <= PHASE_COARSE;
        end else begin
            case (state)
                SEQ_ACCUM: begin
                    if (accept) begin
                        // sample -> pixel -> acquisition order
                        if (!lastSample) begin
                            sampleCnt <= sampleCnt + 1'b1;
                        end else begin
                            sampleCnt <= '0;
                            if (!lastPixel) begin
                                pixel <= pixel + 1'b1;
                            end else begin
                                pixel <= '0;
                                if (!lastAcq) begin
                                    acqCnt <= acqCnt + 1'b1;
                                end else begin
                                    // pass complete
                                    acqCnt  <= '0;
                                    stepCnt <= '0;
                                    state   <= SEQ_DRAIN;
                                end
                            end
                        end
                    end
                end
                SEQ_DRAIN: begin
                    // two cycles so the last count reaches the maxima
                    if (stepCnt == PIX_W'(1)) begin
                        stepCnt <= '0;
                        state   <= SEQ_REPORT;
                    end else begin
                        stepCnt <= stepCnt + 1'b1;
                    end
                end
                SEQ_REPORT: begin
                    // one pixel per cycle
                    if (stepCnt == PIX_W'(PIXEL_NUM - 1)) begin
                        stepCnt <= '0;
                        state   <= SEQ_CLEAR;
                    end else begin
                        stepCnt <= stepCnt + 1'b1;
                    end
                end
                default: begin
                    // clear cycle, flip to the other pass
                    state <= SEQ_ACCUM;
                    phase <= (phase == PHASE_COARSE) ? PHASE_FINE : PHASE_COARSE;
                end
            endcase
        end
    end

endmodule

// ==== hdl/binAddressMapper.sv ====
`timescale 1ns/1ps

module binAddressMapper import histPkg::*; #(
    parameter int DATA_W = DATA_W_DEF,
    parameter int BIN_W  = BIN_W_DEF
) (
    input  logic              accept,
    input  logic [DATA_W-1:0] data,
    input  histPhase_e        phase,
    input  logic [DATA_W-1:0] windowLow,
    output logic              binWrite,
    output logic [BIN_W-1:0]  binIdx
);

    // last offset still inside the fine window
    localparam logic [DATA_W-1:0] SPAN = DATA_W'((2 ** BIN_W) - 1);

    logic [DATA_W-1:0] offset;
    logic              inWindow;

    // distance from the window low edge
    assign offset   = data - windowLow;
    assign inWindow = (data >= windowLow) && (offset <= SPAN);

    always_comb begin
        if (phase == PHASE_COARSE) begin
            // coarse bin is just the top bits
            binIdx   = data[DATA_W-1 -: BIN_W];
            binWrite = accept;
        end else begin
            // fine bins are one code wide
            binIdx   = offset[BIN_W-1:0];
            binWrite = accept && inWindow;
        end
    end

endmodule

// ==== hdl/histPkg.sv ====
package histPkg;

    // default sizes, overridden from the top level
    // sample code width
    parameter int DATA_W_DEF     = 12;
    // log2 of bins per pixel, same in both passes
    parameter int BIN_W_DEF      = 6;
    // bin counter width
    parameter int COUNT_W_DEF    = 8;
    // pixels per frame
    parameter int PIXEL_NUM_DEF  = 4;
    // samples per pixel per acquisition
    parameter int SAMPLE_NUM_DEF = 8;
    // acquisitions per pass
    parameter int ACQ_NUM_DEF    = 2;

    // which pass the histogram is in
    typedef enum logic {
        PHASE_COARSE = 1'b0,
        PHASE_FINE   = 1'b1
    } histPhase_e;

    // sequencer states
    typedef enum logic [1:0] {
        SEQ_ACCUM  = 2'd0,
        SEQ_DRAIN  = 2'd1,
        SEQ_REPORT = 2'd2,
        SEQ_CLEAR  = 2'd3
    } seqState_e;

    // index width for n entries, never below one bit
    function automatic int idxWidth(input int n);
        if (n > 1) begin
            return $clog2(n);
        end
        return 1;
    endfunction

endpackage

// ==== hdl/histogramRam.sv ====
`timescale 1ns/1ps

module histogramRam import histPkg::*; #(
    parameter int BIN_W     = BIN_W_DEF,
    parameter int COUNT_W   = COUNT_W_DEF,
    parameter int PIXEL_NUM = PIXEL_NUM_DEF,
    localparam int PIX_W    = idxWidth(PIXEL_NUM)
) (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               binWrite,
    input  logic               clearHist,
    input  logic [PIX_W-1:0]   pixel,
    input  logic [BIN_W-1:0]   binIdx,
    output logic               binValid,
    output logic [COUNT_W-1:0] binCount,
    output logic [PIX_W-1:0]   binPixel,
    output logic [BIN_W-1:0]   binIdxOut
);

    localparam int BINS   = 2 ** BIN_W;
    localparam int DEPTH  = PIXEL_NUM * BINS;
    localparam int ADDR_W = idxWidth(DEPTH);

    // count storage, register based so a bin can be hit back to back
    logic [COUNT_W-1:0] countMem [DEPTH];
    // a clear flag makes its bin read as zero
    logic [DEPTH-1:0]   validFlag;
    logic [ADDR_W-1:0]  addr;
    logic [COUNT_W-1:0] curCount;
    logic [COUNT_W-1:0] nextCount;

    // pixels laid out one after another
    assign addr      = ADDR_W'(pixel * BINS + binIdx);
    assign curCount  = validFlag[addr] ? countMem[addr] : '0;
    assign nextCount = curCount + COUNT_W'(1);

    // flags and strobe
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            validFlag <= '0;
            binValid  <= 1'b0;
        end else begin
            binValid <= binWrite;
            if (clearHist) begin
                // whole histogram emptied in one cycle
                validFlag <= '0;
            end else if (binWrite) begin
                validFlag[addr] <= 1'b1;
            end
        end
    end

    // counts and the registered result
    always_ff @(posedge clk) begin
        if (binWrite) begin
            countMem[addr] <= nextCount;
            binCount       <= nextCount;
            binPixel       <= pixel;
            binIdxOut      <= binIdx;
        end
    end

endmodule

// ==== hdl/histogramTop.sv ====
`timescale 1ns/1ps

module histogramTop import histPkg::*; #(
    parameter int DATA_W     = DATA_W_DEF,
    parameter int BIN_W      = BIN_W_DEF,
    parameter int COUNT_W    = COUNT_W_DEF,
    parameter int PIXEL_NUM  = PIXEL_NUM_DEF,
    parameter int SAMPLE_NUM = SAMPLE_NUM_DEF,
    parameter int ACQ_NUM    = ACQ_NUM_DEF,
    localparam int PIX_W     = idxWidth(PIXEL_NUM)
) (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               wrEn,
    input  logic [DATA_W-1:0]  data,
    output logic               binValid,
    output logic               busy,
    output logic               peakValid,
    output logic [COUNT_W-1:0] binCount,
    output logic [PIX_W-1:0]   peakPixel,
    output logic [BIN_W-1:0]   peakBin,
    output logic [COUNT_W-1:0] peakCount,
    output histPhase_e         phase,
    output histPhase_e         peakPhase
);

    // sequencer outputs
    logic              accept;
    logic              reportEn;
    logic              clearHist;
    logic [PIX_W-1:0]  pixel;
    logic [PIX_W-1:0]  reportPixel;
    // window and mapping
    logic [DATA_W-1:0] windowLow;
    logic              binWrite;
    logic [BIN_W-1:0]  binIdx;
    // registered bin update towards the tracker
    logic [PIX_W-1:0]  binPixel;
    logic [BIN_W-1:0]  binIdxOut;

    acqSequencer #(
        .PIXEL_NUM  (PIXEL_NUM),
        .SAMPLE_NUM (SAMPLE_NUM),
        .ACQ_NUM    (ACQ_NUM)
    ) i_seq (
        .clk, .combin_res, .wrEn, .accept, .reportEn, .clearHist,
        .busy, .pixel, .reportPixel, .phase
    );

    binAddressMapper #(
        .DATA_W (DATA_W),
        .BIN_W  (BIN_W)
    ) i_mapper (
        .accept, .data, .phase, .windowLow, .binWrite, .binIdx
    );

    histogramRam #(
        .BIN_W     (BIN_W),
        .COUNT_W   (COUNT_W),
        .PIXEL_NUM (PIXEL_NUM)
    ) i_ram (
        .clk, .combin_res, .binWrite, .clearHist, .pixel, .binIdx,
        .binValid, .binCount, .binPixel, .binIdxOut
    );

    peakTracker #(
        .BIN_W     (BIN_W),
        .COUNT_W   (COUNT_W),
        .PIXEL_NUM (PIXEL_NUM)
    ) i_peak (
        .clk, .combin_res, .binValid, .reportEn, .clearHist, .binCount,
        .binPixel, .binIdxOut, .reportPixel, .phase,
        .peakValid, .peakPixel, .peakBin, .peakCount, .peakPhase
    );

    // coarse reports feed back into the fine window
    windowCalculator #(
        .DATA_W    (DATA_W),
        .BIN_W     (BIN_W),
        .PIXEL_NUM (PIXEL_NUM)
    ) i_window (
        .clk, .combin_res, .peakValid, .peakPhase, .peakPixel, .peakBin,
        .pixel, .windowLow
    );

endmodule

// ==== hdl/peakTracker.sv ====
`timescale 1ns/1ps

module peakTracker import histPkg::*; #(
    parameter int BIN_W     = BIN_W_DEF,
    parameter int COUNT_W   = COUNT_W_DEF,
    parameter int PIXEL_NUM = PIXEL_NUM_DEF,
    localparam int PIX_W    = idxWidth(PIXEL_NUM)
) (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               binValid,
    input  logic               reportEn,
    input  logic               clearHist,
    input  logic [COUNT_W-1:0] binCount,
    input  logic [PIX_W-1:0]   binPixel,
    input  logic [BIN_W-1:0]   binIdxOut,
    input  logic [PIX_W-1:0]   reportPixel,
    input  histPhase_e         phase,
    output logic               peakValid,
    output logic [PIX_W-1:0]   peakPixel,
    output logic [BIN_W-1:0]   peakBin,
    output logic [COUNT_W-1:0] peakCount,
    output histPhase_e         peakPhase
);

    // running maximum and its bin, per pixel
    logic [COUNT_W-1:0] runMax [PIXEL_NUM];
    logic [BIN_W-1:0]   runBin [PIXEL_NUM];
    logic               newPeak;

    // strictly greater, so on a tie the earlier bin stays
    assign newPeak = binValid && (binCount > runMax[binPixel]);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < PIXEL_NUM; i++) begin
                runMax[i] <= '0;
                runBin[i] <= '0;
            end
        end else if (clearHist) begin
            // empty pixel reports bin 0, count 0
            for (int i = 0; i < PIXEL_NUM; i++) begin
                runMax[i] <= '0;
                runBin[i] <= '0;
            end
        end else if (newPeak) begin
            runMax[binPixel] <= binCount;
            runBin[binPixel] <= binIdxOut;
        end
    end

    // report strobe
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peakValid <= 1'b0;
        end else begin
            peakValid <= reportEn;
        end
    end

    // report payload, one pixel per cycle
    always_ff @(posedge clk) begin
        if (reportEn) begin
            peakPixel <= reportPixel;
            peakBin   <= runBin[reportPixel];
            peakCount <= runMax[reportPixel];
            peakPhase <= phase;
        end
    end

endmodule

// ==== hdl/windowCalculator.sv ====
`timescale 1ns/1ps

module windowCalculator import histPkg::*; #(
    parameter int DATA_W    = DATA_W_DEF,
    parameter int BIN_W     = BIN_W_DEF,
    parameter int PIXEL_NUM = PIXEL_NUM_DEF,
    localparam int PIX_W    = idxWidth(PIXEL_NUM)
) (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              peakValid,
    input  histPhase_e        peakPhase,
    input  logic [PIX_W-1:0]  peakPixel,
    input  logic [BIN_W-1:0]  peakBin,
    input  logic [PIX_W-1:0]  pixel,
    output logic [DATA_W-1:0] windowLow
);

    // one spare bit for the centre sum
    localparam int EXT_W = DATA_W + 1;
    localparam int SHIFT = DATA_W - BIN_W;
    localparam logic [EXT_W-1:0] HALF_BIN = EXT_W'((2 ** SHIFT) / 2);
    localparam logic [EXT_W-1:0] HALF_WIN = EXT_W'((2 ** BIN_W) / 2);
    // highest low edge that keeps the window in range
    localparam logic [EXT_W-1:0] MAX_LOW  = EXT_W'((2 ** DATA_W) - (2 ** BIN_W));

    logic [DATA_W-1:0] lowEdge [PIXEL_NUM];
    logic [EXT_W-1:0]  centre;
    logic [EXT_W-1:0]  rawLow;
    logic [DATA_W-1:0] clampLow;

    // middle code of the coarse peak bin
    assign centre = (EXT_W'(peakBin) << SHIFT) + HALF_BIN;
    assign rawLow = centre - HALF_WIN;

    always_comb begin
        if (centre < HALF_WIN) begin
            // bottom clamp
            clampLow = '0;
        end else if (rawLow > MAX_LOW) begin
            // top clamp
            clampLow = MAX_LOW[DATA_W-1:0];
        end else begin
            clampLow = rawLow[DATA_W-1:0];
        end
    end

    // only coarse reports move the window
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < PIXEL_NUM; i++) begin
                lowEdge[i] <= '0;
            end
        end else if (peakValid && (peakPhase == PHASE_COARSE)) begin
            lowEdge[peakPixel] <= clampLow;
        end
    end

    assign windowLow = lowEdge[pixel];

endmodule

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module histogramTb -f flist.f -o histSim \
    && ./obj_dir/histSim > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q "Verification failed" sim.log \
    || { cat sim.log 2>/dev/null; echo "simulation run failed"; exit 1; }

// ==== verification/histogramTb.sv ====
`timescale 1ns/1ps

module histogramTb import histPkg::*; ();

    localparam int DATA_W     = DATA_W_DEF;
    localparam int BIN_W      = BIN_W_DEF;
    localparam int COUNT_W    = COUNT_W_DEF;
    localparam int PIXEL_NUM  = PIXEL_NUM_DEF;
    localparam int SAMPLE_NUM = SAMPLE_NUM_DEF;
    localparam int ACQ_NUM    = ACQ_NUM_DEF;
    localparam int PIX_W      = idxWidth(PIXEL_NUM);
    localparam int BINS       = 2 ** BIN_W;
    localparam int SHIFT      = DATA_W - BIN_W;
    // samples of a full pass plus its busy window
    localparam int PASS_LEN   = PIXEL_NUM * SAMPLE_NUM * ACQ_NUM + PIXEL_NUM + 3;
    // reset, coarse pass, fine pass, one restart acquisition
    localparam int TEST_LEN   = 3 + 2 * PASS_LEN + PIXEL_NUM * SAMPLE_NUM;
    localparam int TIMEOUT    = 2 * TEST_LEN;
    localparam logic [31:0] LFSR_SEED = 32'h15783076;

    logic               clk;
    logic               combin_res;
    logic               wrEn;
    logic [DATA_W-1:0]  data;
    logic               binValid;
    logic               busy;
    logic               peakValid;
    logic [COUNT_W-1:0] binCount;
    logic [PIX_W-1:0]   peakPixel;
    logic [BIN_W-1:0]   peakBin;
    logic [COUNT_W-1:0] peakCount;
    histPhase_e         phase;
    histPhase_e         peakPhase;

    // reference model state
    int          modelCount [PIXEL_NUM][BINS];
    int          modelMax [PIXEL_NUM];
    int          modelBin [PIXEL_NUM];
    int          winLow [PIXEL_NUM];
    histPhase_e  modelPhase = PHASE_COARSE;
    logic [31:0] lfsrState  = LFSR_SEED;
    int          valueErrors    = 0;
    int          protocolErrors = 0;
    int          cycleCount     = 0;

    tbClockGen i_clkGen (.clk, .combin_res);

    histogramTop i_dut (
        .clk, .combin_res, .wrEn, .data, .binValid, .busy, .peakValid,
        .binCount, .peakPixel, .peakBin, .peakCount, .phase, .peakPhase
    );

    // x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic int randBits(input int n);
        int   value;
        logic fb;
        value = 0;
        for (int i = 0; i < n; i++) begin
            fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            value     = (value << 1) | int'(fb);
        end
        return value;
    endfunction

    // per pixel coarse ranges: one bin, a tie, a spread, the top bins
    function automatic int coarseCode(input int pix, input int idx);
        int code;
        if (pix % 4 == 0) begin
            code = randBits(SHIFT);
        end else if (pix % 4 == 1) begin
            // bin 20 always reaches each count before bin 10
            code = (((idx % 2 == 0) ? 20 : 10) << SHIFT) + randBits(SHIFT);
        end else if (pix % 4 == 2) begin
            code = (30 << SHIFT) + randBits(SHIFT + 2);
        end else begin
            code = (((idx % 4 == 3) ? BINS - 2 : BINS - 1) << SHIFT) + randBits(SHIFT);
        end
        return code;
    endfunction

    // fine codes near the window edge, optionally one just past it
    function automatic int fineCode(input int pix, input int idx, input bit outside);
        int code;
        if (outside && (idx % 4 == 2)) begin
            code = (winLow[pix] + BINS + randBits(SHIFT)) % (2 ** DATA_W);
        end else if (idx % 2 == 0) begin
            code = winLow[pix] + randBits(BIN_W);
        end else begin
            code = winLow[pix] + randBits(2);
        end
        return code;
    endfunction

    // centre of the coarse peak bin minus half a window, kept in range
    function automatic int windowLowFor(input int peak);
        int low;
        low = (peak << SHIFT) + (2 ** SHIFT) / 2 - BINS / 2;
        if (low < 0) begin
            low = 0;
        end
        if (low > (2 ** DATA_W) - BINS) begin
            low = (2 ** DATA_W) - BINS;
        end
        return low;
    endfunction

    task automatic clearModel();
        for (int p = 0; p < PIXEL_NUM; p++) begin
            modelMax[p] = 0;
            modelBin[p] = 0;
            for (int b = 0; b < BINS; b++) begin
                modelCount[p][b] = 0;
            end
        end
    endtask

    task automatic checkCount(input string name, input logic [COUNT_W-1:0] exp,
                              input logic [COUNT_W-1:0] act);
        if (act !== exp) begin
            valueErrors++;
            $display("Error [%s] count: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic checkBin(input string name, input logic [BIN_W-1:0] exp,
                            input logic [BIN_W-1:0] act);
        if (act !== exp) begin
            valueErrors++;
            $display("Error [%s] bin: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic checkPixel(input string name, input logic [PIX_W-1:0] exp,
                              input logic [PIX_W-1:0] act);
        if (act !== exp) begin
            valueErrors++;
            $display("Error [%s] pixel: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic checkPhase(input string name, input histPhase_e exp, input histPhase_e act);
        if (act !== exp) begin
            valueErrors++;
            $display("Error [%s] phase: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    // one sample in, model updated, DUT result checked one cycle later
    task automatic driveSample(input string name, input int pix, input int code);
        int bin;
        bit hit;
        hit = 1'b1;
        bin = code >> SHIFT;
        if (modelPhase == PHASE_FINE) begin
            hit = (code >= winLow[pix]) && (code <= winLow[pix] + BINS - 1);
            bin = code - winLow[pix];
        end
        wrEn = 1'b1;
        data = DATA_W'(code);
        @(posedge clk);
        #1;
        wrEn = 1'b0;
        if (hit) begin
            modelCount[pix][bin]++;
            // strictly greater, earlier bin keeps a tie
            if (modelCount[pix][bin] > modelMax[pix]) begin
                modelMax[pix] = modelCount[pix][bin];
                modelBin[pix] = bin;
            end
            if (!binValid) begin
                protocolErrors++;
                $display("[%s] sample %0d of pixel %0d was not binned", name, code, pix);
            end
            checkCount(name, COUNT_W'(modelCount[pix][bin]), binCount);
        end else if (binValid) begin
            protocolErrors++;
            $display("[%s] out-of-window sample %0d of pixel %0d was binned", name, code, pix);
        end
    endtask

    // one acquisition in pixel and sample order
    task automatic driveAcquisition(input string name, input bit outside);
        int code;
        for (int pix = 0; pix < PIXEL_NUM; pix++) begin
            for (int s = 0; s < SAMPLE_NUM; s++) begin
                if (modelPhase == PHASE_COARSE) begin
                    code = coarseCode(pix, s);
                end else begin
                    code = fineCode(pix, s, outside);
                end
                driveSample(name, pix, code);
            end
        end
    endtask

    // follows the busy window, checks each report, optionally pokes wrEn
    task automatic checkReport(input string name, input bit pokeBusy);
        int busyCycles;
        int reportIdx;
        busyCycles = 0;
        reportIdx  = 0;
        if (!busy) begin
            protocolErrors++;
            $display("[%s] busy did not rise after the last sample of the pass", name);
        end
        while (busy) begin
            busyCycles++;
            // only the last sample of the pass may still show up here
            if (binValid && (busyCycles > 1)) begin
                protocolErrors++;
                $display("[%s] a sample was binned while busy", name);
            end
            if (peakValid && (reportIdx < PIXEL_NUM)) begin
                checkPixel(name, PIX_W'(reportIdx), peakPixel);
                checkBin(name, BIN_W'(modelBin[reportIdx]), peakBin);
                checkCount(name, COUNT_W'(modelMax[reportIdx]), peakCount);
                checkPhase(name, modelPhase, peakPhase);
                reportIdx++;
            end else if (peakValid) begin
                protocolErrors++;
                $display("[%s] more peak reports than pixels", name);
            end
            if (pokeBusy) begin
                wrEn = 1'b1;
                // inside the window of pixel 0, so a leaked sample would be binned
                data = DATA_W'(winLow[0] + randBits(BIN_W));
            end
            @(posedge clk);
            #1;
            wrEn = 1'b0;
        end
        // result of a sample offered in the clear cycle
        if (binValid) begin
            protocolErrors++;
            $display("[%s] a sample was binned in the clear cycle", name);
        end
        if (reportIdx != PIXEL_NUM) begin
            protocolErrors++;
            $display("[%s] got %0d peak reports instead of %0d", name, reportIdx, PIXEL_NUM);
        end
        if (busyCycles != PIXEL_NUM + 3) begin
            valueErrors++;
            $display("Error [%s] busy cycles: expected %0d, actual %0d",
                     name, PIXEL_NUM + 3, busyCycles);
        end
        // coarse peaks place the fine windows
        if (modelPhase == PHASE_COARSE) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                winLow[p] = windowLowFor(modelBin[p]);
            end
        end
        modelPhase = (modelPhase == PHASE_COARSE) ? PHASE_FINE : PHASE_COARSE;
        checkPhase(name, modelPhase, phase);
        clearModel();
    endtask

    task automatic coarseCountsTest();
        checkPhase("coarse counts", PHASE_COARSE, phase);
        for (int a = 0; a < ACQ_NUM; a++) begin
            driveAcquisition("coarse counts", 1'b0);
        end
    endtask

    task automatic coarsePeakTest();
        checkReport("coarse peak", 1'b0);
    endtask

    // all but the last fine acquisition stay inside the window
    task automatic fineBinningTest();
        for (int a = 0; a < ACQ_NUM - 1; a++) begin
            driveAcquisition("fine binning", 1'b0);
        end
    endtask

    task automatic outOfWindowTest();
        driveAcquisition("out of window", 1'b1);
    endtask

    // fine report with wrEn held during busy, then a fresh coarse acquisition
    task automatic busyRestartTest();
        checkReport("busy restart", 1'b1);
        checkPhase("busy restart", PHASE_COARSE, phase);
        driveAcquisition("busy restart", 1'b0);
    endtask

    // run limit
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        wrEn = 1'b0;
        data = '0;
        clearModel();
        wait (combin_res === 1'b1);
        coarseCountsTest();
        coarsePeakTest();
        fineBinningTest();
        outOfWindowTest();
        busyRestartTest();
        $display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== verification/histogramTb_assert.sv ====
`timescale 1ns/1ps

module histogramTb_assert import histPkg::*; (
    input logic       clk,
    input logic       combin_res,
    input logic       accept,
    input logic       binValid,
    input logic       busy,
    input logic       peakValid,
    input histPhase_e phase
);

    // every bin update comes from a sample taken one cycle earlier
    updateAfterAccept: assert property (@(posedge clk) disable iff (!combin_res)
        binValid |-> $past(accept))
        else $error("binValid without an accepted sample one cycle earlier");

    // coarse samples are always binned
    coarseAlwaysBinned: assert property (@(posedge clk) disable iff (!combin_res)
        (accept && (phase == PHASE_COARSE)) |=> binValid)
        else $error("coarse sample accepted but no binValid one cycle later");

    // peak report only inside the busy window
    reportInsideBusy: assert property (@(posedge clk) disable iff (!combin_res)
        peakValid |-> busy)
        else $error("peakValid seen while not busy");

    // last report cycle and clear cycle carry no bin update
    quietBusyTail: assert property (@(posedge clk) disable iff (!combin_res)
        $fell(busy) |-> (!$past(binValid) && !$past(binValid, 2)))
        else $error("binValid in the last two cycles of busy");

endmodule

bind histogramTop histogramTb_assert i_assert (
    .clk, .combin_res, .accept, .binValid, .busy, .peakValid, .phase
);

// ==== verification/tbClockGen.sv ====
`timescale 1ns/1ps

module tbClockGen (
    output logic clk,
    output logic combin_res
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held low over three rising edges, released just after the third
    initial begin
        combin_res = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        combin_res = 1'b1;
    end

endmodule
